//--- Makefile
VERILATOR  ?= verilator
TOP        := tb_ifu_top
RTL_TOP    := ifu_top
FILELIST   := sources.f
OBJ_DIR    := obj_dir
LOG        := sim.log
SIM_FLAGS  := --binary --timing --assert -j 0
LINT_FLAGS := --lint-only --timing -Wall

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(SIM_FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)

run: build
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	grep -qx "test passed" $(LOG)

lint:
	$(VERILATOR) $(LINT_FLAGS) --top-module $(RTL_TOP) -f $(FILELIST)

clean:
	rm -rf $(OBJ_DIR) $(LOG)

//--- sim/tb_ifu_top.sv
//////////////////////////////////////////////////
// Instruction fetch front end testbench
// Random branches, stalls and OBI grant timing
// from an LFSR, an in-order memory responder and
// a reference model of the fetch stream
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module tb_ifu_top;

  localparam int          FIFO_DEPTH    = 4;
  localparam int          CLK_PERIOD    = 10;
  localparam int          RESET_CYCLES  = 8;
  localparam int          TEST_CYCLES   = 3000;
  localparam int          MARGIN_CYCLES = 500;
  localparam int          WATCHDOG_NS   =
    (RESET_CYCLES + TEST_CYCLES + MARGIN_CYCLES) * CLK_PERIOD;
  localparam logic [31:0] SEED          = 32'hb6f2_6f23;
  localparam logic [31:0] DATA_KEY      = 32'h5a5a_a5a5;

  logic              clk;
  logic              rst_n;
  logic              branch_i;
  ifu_pkg::addr_t    branch_addr_i;
  ifu_pkg::privlvl_t branch_priv_i;
  logic              instr_valid_o;
  logic              instr_ready_i;
  ifu_pkg::addr_t    instr_addr_o;
  ifu_pkg::instr_t   instr_rdata_o;
  ifu_pkg::privlvl_t instr_priv_o;
  logic              obi_req_o;
  logic              obi_gnt_i;
  ifu_pkg::addr_t    obi_addr_o;
  ifu_pkg::privlvl_t obi_priv_o;
  logic              obi_rvalid_i;
  ifu_pkg::instr_t   obi_rdata_i;

  // Random source and memory response queue
  logic [31:0] lfsr_q;
  logic [31:0] rsp_addr_q [$];
  int          rsp_due_q  [$];
  int          cycle;

  // Reference model state
  logic              branch_seen;
  logic [31:0]       exp_pc;
  logic [1:0]        exp_priv;
  logic [31:0]       next_grant_addr;
  logic [1:0]        next_grant_priv;
  logic              skip_stale;
  logic              held_q;
  logic [31:0]       held_addr;
  logic [1:0]        held_priv;
  int                in_flight;

  int mismatch_count;
  int failure_count;
  int grant_count;
  int pop_count;

  ifu_top #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) DUT (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_priv_i (branch_priv_i),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_priv_o  (instr_priv_o),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_o    (obi_addr_o),
    .obi_priv_o    (obi_priv_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  //////////////////////////////////////////////////
  // Random numbers
  //////////////////////////////////////////////////

  // Galois step with taps of x^32 + x^22 + x^2 + x + 1
  function automatic logic [31:0] lfsr_step(input logic [31:0] s);
    return {1'b0, s[31:1]} ^ (s[0] ? 32'h8020_0003 : 32'h0);
  endfunction

  // One LFSR step per bit handed out
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] bits;
    bits = '0;
    for (int i = 0; i < n; i++)
    begin
      lfsr_q = lfsr_step(lfsr_q);
      bits   = {bits[30:0], lfsr_q[0]};
    end
    return bits;
  endfunction

  task automatic report_mismatch(input string name, input logic [31:0] got,
                                 input logic [31:0] expected);
    mismatch_count++;
    $display("mismatch at %0t ns: %s got %h expected %h", $time, name, got, expected);
  endtask

  task automatic report_failure(input string what);
    failure_count++;
    $display("error at %0t ns: %s", $time, what);
  endtask

  //////////////////////////////////////////////////
  // Model and checks on the cycle that just ended
  //////////////////////////////////////////////////

  task automatic check_outputs;
    // Nothing moves until the first branch
    if (!branch_seen && !branch_i)
    begin
      if (obi_req_o)
        report_failure("obi_req_o raised before the first branch");
      if (instr_valid_o)
        report_failure("instr_valid_o raised before the first branch");
    end
    // Ungranted address phase must hold
    if (held_q)
    begin
      if (!obi_req_o)
        report_failure("obi_req_o dropped before its grant");
      if (obi_addr_o !== held_addr)
        report_mismatch("obi_addr_o", obi_addr_o, held_addr);
      if (obi_priv_o !== held_priv)
        report_mismatch("obi_priv_o", 32'(obi_priv_o), 32'(held_priv));
    end
    // Popped word follows the sequential pc
    if (instr_valid_o && instr_ready_i)
    begin
      if (instr_addr_o !== exp_pc)
        report_mismatch("instr_addr_o", instr_addr_o, exp_pc);
      if (instr_rdata_o !== (exp_pc ^ DATA_KEY))
        report_mismatch("instr_rdata_o", instr_rdata_o, exp_pc ^ DATA_KEY);
      if (instr_priv_o !== exp_priv)
        report_mismatch("instr_priv_o", 32'(instr_priv_o), 32'(exp_priv));
      exp_pc = exp_pc + 32'd4;
      in_flight--;
      pop_count++;
    end
    // A request already held in the adapter is granted before the target
    if (branch_i)
    begin
      branch_seen     = 1'b1;
      exp_pc          = branch_addr_i;
      exp_priv        = branch_priv_i;
      next_grant_addr = branch_addr_i;
      next_grant_priv = branch_priv_i;
      skip_stale      = held_q;
      in_flight       = 0;
    end
    if (obi_req_o && obi_gnt_i)
    begin
      grant_count++;
      if (obi_addr_o[1:0] != 2'b00)
        report_failure("granted address is not word aligned");
      if (skip_stale)
      begin
        skip_stale = 1'b0;
      end
      else
      begin
        if (obi_addr_o !== next_grant_addr)
          report_mismatch("obi_addr_o", obi_addr_o, next_grant_addr);
        if (obi_priv_o !== next_grant_priv)
          report_mismatch("obi_priv_o", 32'(obi_priv_o), 32'(next_grant_priv));
        next_grant_addr = next_grant_addr + 32'd4;
        in_flight++;
        if (in_flight > FIFO_DEPTH)
          report_failure("more fetches in flight than the FIFO can hold");
      end
    end
    held_q    = obi_req_o && !obi_gnt_i;
    held_addr = obi_addr_o;
    held_priv = obi_priv_o;
  endtask

  // In-order memory answering 1 to 4 cycles after each grant
  task automatic respond_memory;
    obi_rvalid_i <= 1'b0;
    if (obi_req_o && obi_gnt_i)
    begin
      rsp_addr_q.push_back(obi_addr_o);
      rsp_due_q.push_back(cycle + int'(rand_bits(2)));
    end
    if (rsp_addr_q.size() > 0 && rsp_due_q[0] <= cycle)
    begin
      obi_rvalid_i <= 1'b1;
      obi_rdata_i  <= rsp_addr_q[0] ^ DATA_KEY;
      void'(rsp_addr_q.pop_front());
      void'(rsp_due_q.pop_front());
    end
    obi_gnt_i <= (rand_bits(2) != 32'd0);
  endtask

  task automatic drive_inputs;
    logic [31:0] pick;
    logic [31:0] target;
    logic [31:0] priv;
    // Roughly one branch every 20 cycles
    pick = rand_bits(8);
    if (pick < 32'd13)
    begin
      target        = rand_bits(30);
      priv          = rand_bits(2);
      branch_i      <= 1'b1;
      branch_addr_i <= {target[29:0], 2'b00};
      branch_priv_i <= priv[1:0];
    end
    else
    begin
      branch_i <= 1'b0;
    end
    pick          = rand_bits(1);
    instr_ready_i <= pick[0];
  endtask

  always @(posedge clk)
  begin
    if (rst_n)
    begin
      cycle++;
      check_outputs();
      respond_memory();
      drive_inputs();
    end
  end

  //////////////////////////////////////////////////
  // Run control
  //////////////////////////////////////////////////

  initial
  begin
    clk             = 1'b0;
    rst_n           = 1'b0;
    branch_i        = 1'b0;
    branch_addr_i   = '0;
    branch_priv_i   = '0;
    instr_ready_i   = 1'b0;
    obi_gnt_i       = 1'b0;
    obi_rvalid_i    = 1'b0;
    obi_rdata_i     = '0;
    lfsr_q          = SEED;
    cycle           = 0;
    branch_seen     = 1'b0;
    exp_pc          = '0;
    exp_priv        = '0;
    next_grant_addr = '0;
    next_grant_priv = '0;
    skip_stale      = 1'b0;
    held_q          = 1'b0;
    held_addr       = '0;
    held_priv       = '0;
    in_flight       = 0;
    mismatch_count  = 0;
    failure_count   = 0;
    grant_count     = 0;
    pop_count       = 0;
    repeat (RESET_CYCLES) @(posedge clk);
    rst_n <= 1'b1;
    repeat (TEST_CYCLES) @(posedge clk);
    @(negedge clk);
    if (pop_count == 0)
      report_failure("no instruction was delivered during the run");
    $display("summary: %0d mismatches, %0d other errors, %0d grants, %0d instructions",
             mismatch_count, failure_count, grant_count, pop_count);
    if (mismatch_count == 0 && failure_count == 0)
    begin
      $display("test passed");
    end
    else
    begin
      $display("test failed");
    end
    $finish;
  end

  // Watchdog
  initial
  begin
    #(WATCHDOG_NS);
    $display("watchdog expired before the run completed");
    $display("test failed");
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
src/ifu_pkg.sv
src/ifu_prefetcher.sv
src/ifu_fetch_fifo.sv
src/ifu_bus_adapter.sv
src/ifu_top.sv
sim/tb_ifu_top.sv

//--- src/ifu_bus_adapter.sv
//////////////////////////////////////////////////
// OBI bus adapter
// Turns transaction requests into an OBI address
// phase held stable until granted, and passes the
// in-order responses back to the fetch FIFO
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ifu_bus_adapter (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Transaction request from the prefetcher
  input  wire logic              trans_valid_i,
  output logic                   trans_ready_o,
  input  wire ifu_pkg::addr_t    trans_addr_i,
  input  wire ifu_pkg::privlvl_t trans_priv_i,

  // OBI instruction port
  output logic                   obi_req_o,
  input  wire logic              obi_gnt_i,
  output ifu_pkg::addr_t         obi_addr_o,
  output ifu_pkg::privlvl_t      obi_priv_o,
  input  wire logic              obi_rvalid_i,
  input  wire ifu_pkg::instr_t   obi_rdata_i,

  // Response to the fetch FIFO
  output logic                   resp_valid_o,
  output ifu_pkg::instr_t        resp_rdata_o
);

  logic              full_q;
  ifu_pkg::addr_t    addr_q;
  ifu_pkg::privlvl_t priv_q;

  // Empty register lets a request straight onto the bus
  assign trans_ready_o = !full_q;
  assign obi_req_o     = full_q || trans_valid_i;
  assign obi_addr_o    = full_q ? addr_q : trans_addr_i;
  assign obi_priv_o    = full_q ? priv_q : trans_priv_i;

  // Responses need no reshaping
  assign resp_valid_o = obi_rvalid_i;
  assign resp_rdata_o = obi_rdata_i;

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      full_q <= 1'b0;
    end
    else if (full_q)
    begin
      // Held request leaves once granted
      if (obi_gnt_i)
      begin
        full_q <= 1'b0;
      end
    end
    else if (trans_valid_i && !obi_gnt_i)
    begin
      full_q <= 1'b1;
    end
  end

  // Capture the ungranted request, prefetcher address may move on
  always_ff @(posedge clk)
  begin
    if (!full_q && trans_valid_i && !obi_gnt_i)
    begin
      addr_q <= trans_addr_i;
      priv_q <= trans_priv_i;
    end
  end

  // Address phase holds until the grant
  a_obi_stable : assert property (
    @(posedge clk) disable iff (!rst_n)
    (obi_req_o && !obi_gnt_i) |=>
      (obi_req_o && $stable(obi_addr_o) && $stable(obi_priv_o))
  );

endmodule

`default_nettype wire

//--- src/ifu_fetch_fifo.sv
//////////////////////////////////////////////////
// Fetch FIFO
// Limits outstanding fetches to free space, stores
// returned words, drops responses that belong to
// fetches issued before a branch and hands out
// instructions tagged with address and privilege
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ifu_fetch_fifo #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Branch flushes the ring and resets the pc tag
  input  wire logic              branch_i,
  input  wire ifu_pkg::addr_t    branch_addr_i,
  input  wire ifu_pkg::privlvl_t branch_priv_i,

  // Prefetcher side
  output logic                   fetch_valid_o,
  input  wire logic              fetch_ready_i,

  // Responses from the bus adapter
  input  wire logic              resp_valid_i,
  input  wire ifu_pkg::instr_t   resp_rdata_i,

  // Instruction output
  output logic                   instr_valid_o,
  input  wire logic              instr_ready_i,
  output ifu_pkg::addr_t         instr_addr_o,
  output ifu_pkg::instr_t        instr_rdata_o,
  output ifu_pkg::privlvl_t      instr_priv_o
);

  localparam int PTR_W = $clog2(FIFO_DEPTH);
  localparam int CNT_W = $clog2(FIFO_DEPTH + 1);
  localparam int SUM_W = CNT_W + 2;

  ifu_pkg::instr_t ring_q [FIFO_DEPTH];

  logic [PTR_W-1:0] rptr_q;
  logic [PTR_W-1:0] wptr_q;
  logic [CNT_W-1:0] count_q;
  logic [CNT_W-1:0] out_q;
  logic [CNT_W-1:0] discard_q;
  logic             enabled_q;

  ifu_pkg::addr_t    pc_q;
  ifu_pkg::privlvl_t priv_q;

  logic             pop;
  logic             resp_keep;
  logic             resp_drop;
  logic [SUM_W-1:0] in_use;

  // Responses owed to a flushed stream are dropped first
  assign resp_keep = resp_valid_i && !branch_i && (discard_q == '0);
  assign resp_drop = resp_valid_i && !resp_keep;

  // Stored words vanish on a branch, so they free their slots at once
  assign in_use = SUM_W'(branch_i ? '0 : count_q) + SUM_W'(out_q) + SUM_W'(discard_q);

  assign fetch_valid_o = (enabled_q || branch_i) && (in_use < SUM_W'(FIFO_DEPTH));

  // Head is hidden in a branch cycle, it is stale by then
  assign instr_valid_o = (count_q != '0) && !branch_i;
  assign pop           = instr_valid_o && instr_ready_i;
  assign instr_rdata_o = ring_q[rptr_q];
  assign instr_addr_o  = pc_q;
  assign instr_priv_o  = priv_q;

  //////////////////////////////////////////////////
  // Pointers, counters and pc tag
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      rptr_q    <= '0;
      wptr_q    <= '0;
      count_q   <= '0;
      out_q     <= '0;
      discard_q <= '0;
      enabled_q <= 1'b0;
      pc_q      <= '0;
      priv_q    <= '0;
    end
    else if (branch_i)
    begin
      rptr_q    <= '0;
      wptr_q    <= '0;
      count_q   <= '0;
      // Everything in flight now belongs to the old stream
      discard_q <= discard_q + out_q - CNT_W'(resp_valid_i);
      out_q     <= CNT_W'(fetch_ready_i);
      enabled_q <= 1'b1;
      pc_q      <= branch_addr_i;
      priv_q    <= branch_priv_i;
    end
    else
    begin
      if (resp_keep)
      begin
        wptr_q <= wptr_q + 1'b1;
      end
      if (pop)
      begin
        rptr_q <= rptr_q + 1'b1;
        pc_q   <= pc_q + ifu_pkg::WORD_BYTES;
      end
      count_q   <= count_q + CNT_W'(resp_keep) - CNT_W'(pop);
      out_q     <= out_q + CNT_W'(fetch_ready_i) - CNT_W'(resp_keep);
      discard_q <= discard_q - CNT_W'(resp_drop);
    end
  end

  // Instruction storage
  always_ff @(posedge clk)
  begin
    if (resp_keep)
    begin
      ring_q[wptr_q] <= resp_rdata_i;
    end
  end

  // Memory may only answer a request the FIFO counted
  a_no_spurious_resp : assert property (
    @(posedge clk) disable iff (!rst_n)
    resp_valid_i |-> ((out_q != '0) || (discard_q != '0))
  );

  // Slots in use, stored or owed by the bus, never exceed the depth
  a_no_overflow : assert property (
    @(posedge clk) disable iff (!rst_n)
    (SUM_W'(count_q) + SUM_W'(out_q) + SUM_W'(discard_q)) <= SUM_W'(FIFO_DEPTH)
  );

endmodule

`default_nettype wire

//--- src/ifu_pkg.sv
//////////////////////////////////////////////////
// Instruction fetch shared types
// Address, instruction and privilege widths used
// across the fetch front end, plus the prefetch FSM
// state encoding
//////////////////////////////////////////////////

`default_nettype none

package ifu_pkg;

  // Byte address of one instruction word
  // Low two bits stay zero for any valid fetch
  typedef logic [31:0] addr_t;

  // Raw instruction word as returned by memory
  typedef logic [31:0] instr_t;

  // Privilege level, 2'b00 user, 2'b01 supervisor, 2'b11 machine
  typedef logic [1:0] privlvl_t;

  // Step between two sequential fetches
  localparam addr_t WORD_BYTES = 32'd4;

  // Prefetch FSM states
  typedef enum logic [0:0] {
    IDLE,
    BRANCH_WAIT
  } prefetch_state_e;

endpackage

`default_nettype wire

//--- src/ifu_prefetcher.sv
//////////////////////////////////////////////////
// Instruction prefetcher
// Picks the next fetch address, either a branch
// target or the last accepted address plus one
// word, and issues it as a transaction request
// whenever the fetch FIFO signals room
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ifu_prefetcher (
  input  wire logic             clk,
  input  wire logic             rst_n,

  // Control flow from the core
  input  wire logic             branch_i,
  input  wire ifu_pkg::addr_t   branch_addr_i,
  input  wire ifu_pkg::privlvl_t branch_priv_i,

  // Fetch FIFO side
  input  wire logic             fetch_valid_i,
  output logic                  fetch_ready_o,

  // Transaction request to the bus adapter
  output logic                  trans_valid_o,
  input  wire logic             trans_ready_i,
  output ifu_pkg::addr_t        trans_addr_o,
  output ifu_pkg::privlvl_t     trans_priv_o
);

  ifu_pkg::prefetch_state_e state_q;
  ifu_pkg::prefetch_state_e state_d;

  // Last branch target or last accepted address
  ifu_pkg::addr_t    trans_addr_q;
  ifu_pkg::privlvl_t trans_priv_q;
  ifu_pkg::addr_t    trans_addr_incr;

  // Sequential address for the next word
  assign trans_addr_incr = trans_addr_q + ifu_pkg::WORD_BYTES;

  // FIFO alone decides how many requests may be in flight
  assign trans_valid_o = fetch_valid_i;
  assign fetch_ready_o = trans_valid_o && trans_ready_i;

  //////////////////////////////////////////////////
  // Address select FSM
  //////////////////////////////////////////////////

  always_comb
  begin
    state_d      = state_q;
    trans_addr_o = trans_addr_q;
    trans_priv_o = trans_priv_q;

    case (state_q)
      ifu_pkg::IDLE:
      begin
        // Branch target wins, else keep walking sequentially
        if (branch_i)
        begin
          trans_addr_o = branch_addr_i;
          trans_priv_o = branch_priv_i;
        end
        else
        begin
          trans_addr_o = trans_addr_incr;
        end
        // Target not taken by the adapter yet, hold it for replay
        if (branch_i && !fetch_ready_o)
        begin
          state_d = ifu_pkg::BRANCH_WAIT;
        end
      end

      ifu_pkg::BRANCH_WAIT:
      begin
        // Replay stored target unless a newer branch overrides it
        if (branch_i)
        begin
          trans_addr_o = branch_addr_i;
          trans_priv_o = branch_priv_i;
        end
        if (fetch_ready_o)
        begin
          state_d = ifu_pkg::IDLE;
        end
      end

      default:
      begin
        state_d = ifu_pkg::IDLE;
      end
    endcase
  end

  //////////////////////////////////////////////////
  // Registers
  //////////////////////////////////////////////////

  always_ff @(posedge clk or negedge rst_n)
  begin
    if (!rst_n)
    begin
      state_q      <= ifu_pkg::IDLE;
      trans_addr_q <= '0;
      trans_priv_q <= '0;
    end
    else
    begin
      state_q <= state_d;
      // Remember the target or the address just handed out
      if (branch_i || fetch_ready_o)
      begin
        trans_addr_q <= trans_addr_o;
        trans_priv_q <= trans_priv_o;
      end
    end
  end

  // Branch targets from the core must be word aligned
  a_trans_aligned : assert property (
    @(posedge clk) disable iff (!rst_n)
    trans_valid_o |-> (trans_addr_o[1:0] == 2'b00)
  );

endmodule

`default_nettype wire

//--- src/ifu_top.sv
//////////////////////////////////////////////////
// Instruction fetch front end
// Prefetcher, fetch FIFO and OBI bus adapter
//////////////////////////////////////////////////

`timescale 1ns/1ns
`default_nettype none

module ifu_top #(
  parameter int FIFO_DEPTH = 4
) (
  input  wire logic              clk,
  input  wire logic              rst_n,

  // Branch request, one cycle pulse
  input  wire logic              branch_i,
  input  wire ifu_pkg::addr_t    branch_addr_i,
  input  wire ifu_pkg::privlvl_t branch_priv_i,

  // Instruction output
  output logic                   instr_valid_o,
  input  wire logic              instr_ready_i,
  output ifu_pkg::addr_t         instr_addr_o,
  output ifu_pkg::instr_t        instr_rdata_o,
  output ifu_pkg::privlvl_t      instr_priv_o,

  // OBI instruction port
  output logic                   obi_req_o,
  input  wire logic              obi_gnt_i,
  output ifu_pkg::addr_t         obi_addr_o,
  output ifu_pkg::privlvl_t      obi_priv_o,
  input  wire logic              obi_rvalid_i,
  input  wire ifu_pkg::instr_t   obi_rdata_i
);

  // FIFO to prefetcher
  logic fetch_valid;
  logic fetch_ready;

  // Prefetcher to bus adapter
  logic              trans_valid;
  logic              trans_ready;
  ifu_pkg::addr_t    trans_addr;
  ifu_pkg::privlvl_t trans_priv;

  // Bus adapter to FIFO
  logic            resp_valid;
  ifu_pkg::instr_t resp_rdata;

  ifu_prefetcher u_prefetcher (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_priv_i (branch_priv_i),
    .fetch_valid_i (fetch_valid),
    .fetch_ready_o (fetch_ready),
    .trans_valid_o (trans_valid),
    .trans_ready_i (trans_ready),
    .trans_addr_o  (trans_addr),
    .trans_priv_o  (trans_priv)
  );

  ifu_bus_adapter u_bus_adapter (
    .clk           (clk),
    .rst_n         (rst_n),
    .trans_valid_i (trans_valid),
    .trans_ready_o (trans_ready),
    .trans_addr_i  (trans_addr),
    .trans_priv_i  (trans_priv),
    .obi_req_o     (obi_req_o),
    .obi_gnt_i     (obi_gnt_i),
    .obi_addr_o    (obi_addr_o),
    .obi_priv_o    (obi_priv_o),
    .obi_rvalid_i  (obi_rvalid_i),
    .obi_rdata_i   (obi_rdata_i),
    .resp_valid_o  (resp_valid),
    .resp_rdata_o  (resp_rdata)
  );

  ifu_fetch_fifo #(
    .FIFO_DEPTH (FIFO_DEPTH)
  ) u_fetch_fifo (
    .clk           (clk),
    .rst_n         (rst_n),
    .branch_i      (branch_i),
    .branch_addr_i (branch_addr_i),
    .branch_priv_i (branch_priv_i),
    .fetch_valid_o (fetch_valid),
    .fetch_ready_i (fetch_ready),
    .resp_valid_i  (resp_valid),
    .resp_rdata_i  (resp_rdata),
    .instr_valid_o (instr_valid_o),
    .instr_ready_i (instr_ready_i),
    .instr_addr_o  (instr_addr_o),
    .instr_rdata_o (instr_rdata_o),
    .instr_priv_o  (instr_priv_o)
  );

endmodule

`default_nettype wire
